//--- design/fetch_pkg.sv
package fetch_pkg;

  // redirect source for the fetch pc
  typedef enum logic [1:0] {
    PC_BOOT = 2'd0,
    PC_JUMP = 2'd1,
    PC_TRAP = 2'd2
  } pc_src_e;

  // major opcodes used by the expanded forms
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_OP     = 7'h33;

  // fields of a 16-bit compressed parcel, CI / CR layout
  typedef struct packed {
    logic [2:0] funct3;
    logic       bit12;
    logic [4:0] rd;
    logic [4:0] imm_rs2;
    logic [1:0] quadrant;
  } c_parcel_s;

  // upper parcel kept raw, lower parcel split into fields
  typedef struct packed {
    logic [15:0] upper;
    c_parcel_s   lower;
  } fetch_parcels_s;

  // one fetched word, seen either whole or as parcels
  typedef union packed {
    logic [31:0]    instr;
    fetch_parcels_s parcels;
  } fetch_word_u;

  // queue element, the word together with its halfword pc
  typedef struct packed {
    logic [31:0] pc;
    fetch_word_u word;
  } fetch_entry_s;

  // IF/ID payload
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic        is_compressed;
    logic        illegal_c;
  } if_id_s;

endpackage

//--- design/cfg_pkg.sv
package cfg_pkg;

  // APB request as driven by the bus master
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_s;

  // APB response from the register block
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_s;

  // configuration seen by the fetch unit
  typedef struct packed {
    logic [31:0] boot_addr;
    logic [23:0] trap_base;
    logic        enable;
  } fetch_cfg_s;

  // register map
  localparam logic [7:0] REG_BOOT  = 8'h00;
  localparam logic [7:0] REG_TRAP  = 8'h04;
  localparam logic [7:0] REG_CTRL  = 8'h08;
  localparam logic [7:0] REG_COUNT = 8'h0C;

  // boot address out of reset
  localparam logic [31:0] BOOT_RESET = 32'h0000_0100;

endpackage

//--- design/fetch_cfg_regs.sv
module fetch_cfg_regs import cfg_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  apb_req_s   apb_req_i,
  output apb_rsp_s   apb_rsp_o,
  input  logic       deliver_i,
  output fetch_cfg_s cfg_o
);

  logic [31:0] boot_q;
  logic [23:0] trap_q;
  logic        enable_q;
  logic [31:0] count_q;

  logic access;
  logic sel_boot, sel_trap, sel_ctrl, sel_count;
  logic mapped;
  logic wr_en;
  logic [31:0] rdata;

  // ---------------------------------------------------------------------------
  // address decode
  // ---------------------------------------------------------------------------

  // access phase, the setup cycle has penable low
  assign access    = apb_req_i.psel & apb_req_i.penable;
  assign sel_boot  = apb_req_i.paddr == REG_BOOT;
  assign sel_trap  = apb_req_i.paddr == REG_TRAP;
  assign sel_ctrl  = apb_req_i.paddr == REG_CTRL;
  assign sel_count = apb_req_i.paddr == REG_COUNT;
  assign mapped    = sel_boot | sel_trap | sel_ctrl | sel_count;

  // count is read only, writes to it are dropped
  assign wr_en = access & apb_req_i.pwrite & mapped & ~sel_count;

  // read mux, unmapped offsets return zero
  always_comb begin
    rdata = '0;
    if (sel_boot)  rdata = boot_q;
    if (sel_trap)  rdata = {8'h00, trap_q};
    if (sel_ctrl)  rdata = {31'b0, enable_q};
    if (sel_count) rdata = count_q;
  end

  // no wait states
  assign apb_rsp_o.pready  = access;
  assign apb_rsp_o.pslverr = access & (~mapped | (apb_req_i.pwrite & sel_count));
  assign apb_rsp_o.prdata  = (access & ~apb_req_i.pwrite) ? rdata : '0;

  // ---------------------------------------------------------------------------
  // registers
  // ---------------------------------------------------------------------------

  // writes land at the end of the access cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      boot_q   <= BOOT_RESET;
      trap_q   <= '0;
      enable_q <= 1'b0;
    end else if (wr_en) begin
      if (sel_boot) boot_q   <= apb_req_i.pwdata;
      if (sel_trap) trap_q   <= apb_req_i.pwdata[23:0];
      if (sel_ctrl) enable_q <= apb_req_i.pwdata[0];
    end
  end

  // items handed to decode
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (deliver_i) begin
      count_q <= count_q + 32'd1;
    end
  end

  assign cfg_o.boot_addr = boot_q;
  assign cfg_o.trap_base = trap_q;
  assign cfg_o.enable    = enable_q;

endmodule

//--- design/fetch_unit.sv
module fetch_unit import fetch_pkg::*, cfg_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  fetch_cfg_s   cfg_i,
  input  logic         pc_set_i,
  input  pc_src_e      pc_mux_i,
  input  logic [31:0]  jump_target_i,
  input  logic         queue_room_i,
  output logic         instr_req_o,
  output logic [31:0]  instr_addr_o,
  input  logic         instr_gnt_i,
  input  logic         instr_rvalid_i,
  input  logic [31:0]  instr_rdata_i,
  output logic         push_o,
  output fetch_entry_s push_data_o,
  output logic         flush_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} state_e;

  state_e      state_q, state_d;
  logic [31:0] pc_q, pc_d;
  logic [31:0] addr_q, addr_d;
  logic        stale_q, stale_d;
  logic        boot_pend_q, boot_pend_d;
  logic [31:0] redirect_pc;
  logic [31:0] fetch_pc;
  logic [31:0] next_pc;
  logic        can_issue;
  fetch_word_u rdata_w;

  assign rdata_w = fetch_word_u'(instr_rdata_i);

  // redirect target, trap base sits above eight zero bits
  always_comb begin
    case (pc_mux_i)
      PC_JUMP: redirect_pc = jump_target_i;
      PC_TRAP: redirect_pc = {cfg_i.trap_base, 8'h00};
      default: redirect_pc = cfg_i.boot_addr;
    endcase
    // halfword aligned
    redirect_pc[0] = 1'b0;
  end

  // until the first fetch the pc follows the boot register
  assign fetch_pc  = boot_pend_q ? {cfg_i.boot_addr[31:1], 1'b0} : pc_q;
  // 32-bit words end in 11, everything else is a parcel
  assign next_pc   = addr_q + ((rdata_w.parcels.lower.quadrant == 2'b11) ? 32'd4 : 32'd2);
  // a redirect flushes the queue, so room is implied then
  assign can_issue = cfg_i.enable & (queue_room_i | pc_set_i);

  // ---------------------------------------------------------------------------
  // request FSM, one outstanding request at most
  // ---------------------------------------------------------------------------
  always_comb begin
    state_d     = state_q;
    pc_d        = pc_q;
    addr_d      = addr_q;
    stale_d     = stale_q;
    boot_pend_d = boot_pend_q;
    push_o      = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (pc_set_i) begin
          pc_d        = redirect_pc;
          boot_pend_d = 1'b0;
          if (cfg_i.enable) begin
            addr_d  = redirect_pc;
            state_d = ST_REQ;
          end
        end else if (can_issue) begin
          pc_d        = fetch_pc;
          addr_d      = fetch_pc;
          boot_pend_d = 1'b0;
          state_d     = ST_REQ;
        end
      end
      ST_REQ: begin
        // address must hold until grant, so only the pc moves
        if (pc_set_i) begin
          pc_d    = redirect_pc;
          stale_d = 1'b1;
        end
        if (instr_gnt_i) state_d = ST_WAIT;
      end
      ST_WAIT: begin
        if (instr_rvalid_i) begin
          // drop abandoned words and words racing a redirect
          push_o  = ~stale_q & ~pc_set_i;
          stale_d = 1'b0;
          if (pc_set_i) pc_d = redirect_pc;
          else if (!stale_q) pc_d = next_pc;
          if (can_issue) begin
            addr_d  = pc_d;
            state_d = ST_REQ;
          end else begin
            state_d = ST_IDLE;
          end
        end else if (pc_set_i) begin
          pc_d    = redirect_pc;
          stale_d = 1'b1;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= ST_IDLE;
      pc_q        <= BOOT_RESET;
      addr_q      <= '0;
      stale_q     <= 1'b0;
      boot_pend_q <= 1'b1;
    end else begin
      state_q     <= state_d;
      pc_q        <= pc_d;
      addr_q      <= addr_d;
      stale_q     <= stale_d;
      boot_pend_q <= boot_pend_d;
    end
  end

  assign instr_req_o  = state_q == ST_REQ;
  assign instr_addr_o = addr_q;
  assign flush_o      = pc_set_i;
  assign push_data_o  = '{pc: addr_q, word: rdata_w};

endmodule

//--- design/fetch_queue.sv
module fetch_queue import fetch_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         flush_i,
  input  logic         push_i,
  input  fetch_entry_s push_data_i,
  input  logic         pop_i,
  output fetch_entry_s head_o,
  output logic         head_valid_o,
  output logic         room_o
);

  localparam int AW = $clog2(DEPTH);

  fetch_entry_s  mem_q [DEPTH];
  logic [AW-1:0] wr_ptr_q, rd_ptr_q;
  logic [AW:0]   count_q;
  logic          do_push, do_pop;

  // flush wins over both ends
  assign do_push = push_i & ~flush_i;
  assign do_pop  = pop_i & head_valid_o & ~flush_i;

  // storage
  always_ff @(posedge clk) begin
    if (do_push) mem_q[wr_ptr_q] <= push_data_i;
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_push && !do_pop) count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
    end
  end

  assign head_o       = mem_q[rd_ptr_q];
  assign head_valid_o = count_q != '0;
  // two free slots, one is for the word still in memory
  assign room_o       = count_q <= (AW + 1)'(DEPTH - 2);

endmodule

//--- design/compressed_expander.sv
module compressed_expander import fetch_pkg::*; (
  input  fetch_word_u word_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_o
);

  c_parcel_s   p;
  logic [11:0] imm12;

  assign p = word_i.parcels.lower;

  // CI immediate, sign extended from bit 12
  assign imm12 = {{6{p.bit12}}, p.bit12, p.imm_rs2};

  // low bits 11 mark a full word
  assign is_compressed_o = p.quadrant != 2'b11;

  always_comb begin
    // unsupported parcels go out zero extended
    instr_o   = {16'h0000, p};
    illegal_o = 1'b0;
    if (!is_compressed_o) begin
      instr_o = word_i.instr;
    end else begin
      illegal_o = 1'b1;
      case (p.quadrant)
        2'b01: begin
          // c.addi, addi rd, rd, imm
          if (p.funct3 == 3'b000) begin
            instr_o   = {imm12, p.rd, 3'b000, p.rd, OPC_OP_IMM};
            illegal_o = 1'b0;
          end
          // c.li, addi rd, x0, imm
          if (p.funct3 == 3'b010) begin
            instr_o   = {imm12, 5'd0, 3'b000, p.rd, OPC_OP_IMM};
            illegal_o = 1'b0;
          end
        end
        2'b10: begin
          // rs2 of zero is jr / jalr / ebreak, not handled here
          if (p.funct3 == 3'b100 && p.imm_rs2 != 5'd0) begin
            illegal_o = 1'b0;
            if (p.bit12) begin
              // c.add, add rd, rd, rs2
              instr_o = {7'b0, p.imm_rs2, p.rd, 3'b000, p.rd, OPC_OP};
            end else begin
              // c.mv, add rd, x0, rs2
              instr_o = {7'b0, p.imm_rs2, 5'd0, 3'b000, p.rd, OPC_OP};
            end
          end
        end
        // quadrant 0 is entirely unsupported
        default: illegal_o = 1'b1;
      endcase
    end
  end

endmodule

//--- design/if_stage.sv
module if_stage import fetch_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         flush_i,
  input  fetch_entry_s head_i,
  input  logic         head_valid_i,
  output logic         pop_o,
  input  logic         id_ready_i,
  output logic         instr_valid_o,
  output if_id_s       if_id_o
);

  logic        valid_q;
  if_id_s      if_id_q;
  logic [31:0] exp_instr;
  logic        exp_compressed;
  logic        exp_illegal;
  logic        slot_free;

  compressed_expander i_expander (
    .word_i          (head_i.word),
    .instr_o         (exp_instr),
    .is_compressed_o (exp_compressed),
    .illegal_o       (exp_illegal)
  );

  // slot opens when empty or when decode takes the current item
  assign slot_free = ~valid_q | id_ready_i;
  assign pop_o     = head_valid_i & slot_free & ~flush_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (pop_o) begin
      valid_q <= 1'b1;
    end else if (id_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // payload only moves on a pop, it holds while stalled
  always_ff @(posedge clk) begin
    if (pop_o) begin
      if_id_q <= '{pc: head_i.pc, instr: exp_instr,
                   is_compressed: exp_compressed, illegal_c: exp_illegal};
    end
  end

  assign instr_valid_o = valid_q;
  assign if_id_o       = if_id_q;

endmodule

//--- design/fetch_top.sv
module fetch_top import fetch_pkg::*, cfg_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  apb_req_s    apb_req_i,
  output apb_rsp_s    apb_rsp_o,
  input  logic        pc_set_i,
  input  pc_src_e     pc_mux_i,
  input  logic [31:0] jump_target_i,
  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i,
  input  logic        id_ready_i,
  output logic        instr_valid_o,
  output if_id_s      if_id_o
);

  fetch_cfg_s   cfg;
  logic         queue_room;
  logic         push;
  fetch_entry_s push_data;
  logic         flush;
  fetch_entry_s head;
  logic         head_valid;
  logic         pop;
  logic         deliver;

  // an item counts as delivered when decode accepts it
  assign deliver = instr_valid_o & id_ready_i;

  fetch_cfg_regs i_cfg_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .deliver_i (deliver),
    .cfg_o     (cfg)
  );

  fetch_unit i_fetch_unit (
    .clk            (clk),
    .rst_n          (rst_n),
    .cfg_i          (cfg),
    .pc_set_i       (pc_set_i),
    .pc_mux_i       (pc_mux_i),
    .jump_target_i  (jump_target_i),
    .queue_room_i   (queue_room),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .push_o         (push),
    .push_data_o    (push_data),
    .flush_o        (flush)
  );

  fetch_queue #(.DEPTH(QUEUE_DEPTH)) i_fetch_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush),
    .push_i       (push),
    .push_data_i  (push_data),
    .pop_i        (pop),
    .head_o       (head),
    .head_valid_o (head_valid),
    .room_o       (queue_room)
  );

  // redirect flush also clears the IF/ID slot
  if_stage i_if_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush),
    .head_i        (head),
    .head_valid_i  (head_valid),
    .pop_o         (pop),
    .id_ready_i    (id_ready_i),
    .instr_valid_o (instr_valid_o),
    .if_id_o       (if_id_o)
  );

endmodule

//--- sim/fetch_asserts.sv
module fetch_asserts import fetch_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic        req_i,
  input logic        gnt_i,
  input logic [31:0] addr_i,
  input logic        valid_i,
  input logic        ready_i,
  input if_id_s      if_id_i
);

  // grant only while requesting
  a_gnt_req: assert property (@(posedge clk) disable iff (!rst_n) gnt_i |-> req_i)
    else $error("instruction grant without a request");

  // address held until grant
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    req_i && !gnt_i |=> $stable(addr_i))
    else $error("instruction address moved while the request was pending");

  // stalled payload holds
  a_ifid_stable: assert property (@(posedge clk) disable iff (!rst_n)
    valid_i && !ready_i |=> $stable(if_id_i))
    else $error("IF/ID payload changed under stall");

endmodule

bind fetch_unit fetch_asserts i_mem_asserts (
  .clk (clk), .rst_n (rst_n), .req_i (instr_req_o), .gnt_i (instr_gnt_i),
  .addr_i (instr_addr_o), .valid_i (1'b0), .ready_i (1'b1), .if_id_i ('0)
);

bind if_stage fetch_asserts i_ifid_asserts (
  .clk (clk), .rst_n (rst_n), .req_i (1'b0), .gnt_i (1'b0), .addr_i (32'h0),
  .valid_i (instr_valid_o), .ready_i (id_ready_i), .if_id_i (if_id_o)
);

//--- sim/tb_fetch_top.sv
module tb_fetch_top import fetch_pkg::*, cfg_pkg::*;;

  logic        clk;
  logic        rst_n;
  apb_req_s    apb_req;
  apb_rsp_s    apb_rsp;
  logic        pc_set;
  pc_src_e     pc_mux;
  logic [31:0] jump_target;
  logic        instr_req;
  logic [31:0] instr_addr;
  logic        instr_gnt;
  logic        instr_rvalid;
  logic [31:0] instr_rdata;
  logic        id_ready;
  logic        instr_valid;
  if_id_s      if_id;

  int          errors;
  int          consumed;
  int          test_err_base;
  logic [31:0] exp_pc;
  logic [31:0] redirect_pc_exp;
  logic [1:0]  rdy_mode;
  logic        outstanding;
  logic [31:0] rd_data;
  logic        rd_err;

  fetch_top #(.QUEUE_DEPTH(4)) i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .apb_req_i      (apb_req),
    .apb_rsp_o      (apb_rsp),
    .pc_set_i       (pc_set),
    .pc_mux_i       (pc_mux),
    .jump_target_i  (jump_target),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata),
    .id_ready_i     (id_ready),
    .instr_valid_o  (instr_valid),
    .if_id_o        (if_id)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // ------------------------------------------------------------------------
  // LFSR and memory contents
  // ------------------------------------------------------------------------

  // fibonacci, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  task automatic draw_bits(input int n, inout logic [31:0] s, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      s = lfsr_next(s);
      v = {v[6:0], s[0]};
    end
  endtask

  // word at a halfword address, low parcel cycles through six kinds
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] s;
    logic [31:0] w;
    s = 32'h492a ^ (addr << 1);
    for (int i = 0; i < 32; i++) s = lfsr_next(s);
    w = s;
    case ((addr >> 1) % 6)
      0: w[1:0] = 2'b11;
      1: begin
        w[1:0] = 2'b01;
        w[15:13] = 3'b000;
      end
      2: begin
        w[1:0] = 2'b01;
        w[15:13] = 3'b010;
      end
      3: begin
        w[1:0] = 2'b10;
        w[15:13] = 3'b100;
        w[12] = 1'b0;
        w[2] = 1'b1;
      end
      4: begin
        w[1:0] = 2'b10;
        w[15:13] = 3'b100;
        w[12] = 1'b1;
        w[2] = 1'b1;
      end
      default: w[1:0] = 2'b00;
    endcase
    return w;
  endfunction

  // expected IF/ID payload for the item at pc
  function automatic if_id_s ref_item(input logic [31:0] pc);
    logic [31:0] w;
    logic [11:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    if_id_s      r;
    w   = mem_word(pc);
    imm = {{7{w[12]}}, w[6:2]};
    rd  = w[11:7];
    rs2 = w[6:2];
    r.pc = pc;
    r.is_compressed = w[1:0] != 2'b11;
    r.illegal_c = 1'b0;
    r.instr = w;
    if (r.is_compressed) begin
      r.illegal_c = 1'b1;
      r.instr = {16'h0, w[15:0]};
      if (w[1:0] == 2'b01 && w[15:13] == 3'b000) begin
        r.instr = {imm, rd, 3'b000, rd, 7'h13};
        r.illegal_c = 1'b0;
      end else if (w[1:0] == 2'b01 && w[15:13] == 3'b010) begin
        r.instr = {imm, 5'd0, 3'b000, rd, 7'h13};
        r.illegal_c = 1'b0;
      end else if (w[1:0] == 2'b10 && w[15:13] == 3'b100 && rs2 != 5'd0) begin
        r.instr = {7'd0, rs2, w[12] ? rd : 5'd0, 3'b000, rd, 7'h33};
        r.illegal_c = 1'b0;
      end
    end
    return r;
  endfunction

  // ------------------------------------------------------------------------
  // memory model, one request at a time with random delays
  // ------------------------------------------------------------------------
  initial begin
    logic [31:0] s;
    logic [7:0]  d;
    logic [31:0] a;
    s = 32'h492a;
    instr_gnt = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata = '0;
    outstanding = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      instr_rvalid = 1'b0;
      if (instr_req) begin
        a = instr_addr;
        draw_bits(2, s, d);
        repeat (d) begin
          @(posedge clk);
          #2;
        end
        instr_gnt = 1'b1;
        outstanding = 1'b1;
        @(posedge clk);
        #2;
        instr_gnt = 1'b0;
        draw_bits(2, s, d);
        repeat (d) begin
          @(posedge clk);
          #2;
        end
        instr_rvalid = 1'b1;
        instr_rdata = mem_word(a);
        outstanding = 1'b0;
      end
    end
  end

  // decode side ready, random, mostly low, held low or held high
  initial begin
    logic [31:0] s;
    logic [7:0]  v;
    s = 32'h492a;
    id_ready = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      draw_bits(3, s, v);
      case (rdy_mode)
        2'd0: id_ready = v[1:0] != 2'b00;
        2'd1: id_ready = v[2:0] == 3'b000;
        2'd2: id_ready = 1'b0;
        default: id_ready = 1'b1;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // comparison of consumed items against the reference walk
  // ------------------------------------------------------------------------
  initial begin
    if_id_s e;
    forever begin
      @(posedge clk);
      #4;
      if (rst_n && instr_valid && id_ready) begin
        e = ref_item(exp_pc);
        if (if_id.pc !== e.pc) begin
          $display("Error: if_id_o.pc got %h expected %h", if_id.pc, e.pc);
          errors++;
        end
        if (if_id.instr !== e.instr) begin
          $display("Error: if_id_o.instr got %h expected %h at pc %h",
                   if_id.instr, e.instr, e.pc);
          errors++;
        end
        if (if_id.is_compressed !== e.is_compressed) begin
          $display("Error: if_id_o.is_compressed got %h expected %h",
                   if_id.is_compressed, e.is_compressed);
          errors++;
        end
        if (if_id.illegal_c !== e.illegal_c) begin
          $display("Error: if_id_o.illegal_c got %h expected %h",
                   if_id.illegal_c, e.illegal_c);
          errors++;
        end
        consumed++;
        // next item sits past this one, two bytes for a parcel, four for a word
        exp_pc = e.pc + (e.is_compressed ? 32'd2 : 32'd4);
      end
      // items consumed at the flush edge still belong to the old stream
      if (pc_set) exp_pc = redirect_pc_exp;
    end
  end

  // ------------------------------------------------------------------------
  // stimulus tasks
  // ------------------------------------------------------------------------
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int n;
    @(posedge clk);
    #2;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    #2;
    apb_req.penable = 1'b1;
    #1;
    n = 0;
    while (!apb_rsp.pready && n < 10) begin
      @(posedge clk);
      #3;
      n++;
    end
    if (!apb_rsp.pready) begin
      $display("APB transfer to offset %h never saw pready", addr);
      errors++;
    end
    rdata = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    @(posedge clk);
    #2;
    apb_req = '0;
  endtask

  task automatic apb_check(input logic [7:0] addr, input logic [31:0] exp);
    apb_xfer(1'b0, addr, '0, rd_data, rd_err);
    if (rd_data !== exp || rd_err !== 1'b0) begin
      $display("Error: prdata at %h got %h expected %h (pslverr %h)",
               addr, rd_data, exp, rd_err);
      errors++;
    end
  endtask

  task automatic wait_items(input int target);
    int n;
    n = 0;
    while (consumed < target && n < 5000) begin
      @(posedge clk);
      n++;
    end
    if (consumed < target) begin
      $display("timed out with %0d of %0d items consumed", consumed, target);
      errors++;
    end
  endtask

  // optionally hold off until a response is outstanding
  task automatic do_redirect(input pc_src_e src, input logic [31:0] target,
                             input logic [31:0] expect_pc, input logic hit_pending);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #3;
      n++;
    end while (hit_pending && !outstanding && n < 200);
    if (hit_pending && !outstanding) begin
      $display("no outstanding response seen before redirect");
      errors++;
    end
    redirect_pc_exp = expect_pc;
    pc_mux = src;
    jump_target = target;
    pc_set = 1'b1;
    @(posedge clk);
    #3;
    pc_set = 1'b0;
  endtask

  task automatic report_test(input string name);
    $display("test %s: %0d errors, %0d items consumed so far",
             name, errors - test_err_base, consumed);
    test_err_base = errors;
  endtask

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------
  initial begin
    apb_req = '0;
    pc_set = 1'b0;
    pc_mux = PC_BOOT;
    jump_target = '0;
    rst_n = 1'b0;
    errors = 0;
    consumed = 0;
    test_err_base = 0;
    exp_pc = 32'h100;
    redirect_pc_exp = 32'h100;
    rdy_mode = 2'd0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // 1. register access and reset state
    #1;
    if (instr_req !== 1'b0 || instr_valid !== 1'b0 || apb_rsp.pready !== 1'b0 ||
        apb_rsp.pslverr !== 1'b0) begin
      $display("Error: after reset instr_req %h instr_valid %h pready %h pslverr %h, expected 0",
               instr_req, instr_valid, apb_rsp.pready, apb_rsp.pslverr);
      errors++;
    end
    apb_check(REG_COUNT, 32'h0);
    apb_check(REG_BOOT, 32'h100);
    apb_xfer(1'b1, REG_BOOT, 32'h0000_0a40, rd_data, rd_err);
    apb_check(REG_BOOT, 32'h0000_0a40);
    apb_xfer(1'b1, REG_BOOT, 32'h0000_0100, rd_data, rd_err);
    apb_xfer(1'b1, REG_TRAP, 32'h0000_0012, rd_data, rd_err);
    apb_check(REG_TRAP, 32'h0000_0012);
    apb_xfer(1'b1, REG_COUNT, 32'h55, rd_data, rd_err);
    if (rd_err !== 1'b1) begin
      $display("Error: pslverr on count register write got %h expected 1", rd_err);
      errors++;
    end
    apb_xfer(1'b0, 8'h10, '0, rd_data, rd_err);
    if (rd_err !== 1'b1 || rd_data !== 32'h0) begin
      $display("Error: unmapped read pslverr %h prdata %h expected 1 and 00000000",
               rd_err, rd_data);
      errors++;
    end
    apb_check(REG_COUNT, 32'h0);
    report_test("apb_registers");

    // 2. stream from boot address
    apb_xfer(1'b1, REG_CTRL, 32'h1, rd_data, rd_err);
    wait_items(40);
    report_test("boot_stream");

    // 3. long decode stalls
    #1;
    rdy_mode = 2'd1;
    wait_items(consumed + 25);
    #1;
    rdy_mode = 2'd0;
    report_test("back_pressure");

    // 4. jump while a response is pending, jump mid-stream, then trap
    do_redirect(PC_JUMP, 32'h2000, 32'h2000, 1'b1);
    wait_items(consumed + 12);
    do_redirect(PC_JUMP, 32'h3106, 32'h3106, 1'b0);
    wait_items(consumed + 12);
    do_redirect(PC_TRAP, 32'h0, 32'h1200, 1'b0);
    wait_items(consumed + 12);
    report_test("redirects");

    // 5. delivered count against the testbench count
    #1;
    rdy_mode = 2'd2;
    repeat (3) @(posedge clk);
    apb_check(REG_COUNT, consumed);
    report_test("delivered_count");

    $display("checks done: %0d items consumed, %0d errors", consumed, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // global cycle limit
  initial begin
    repeat (60000) @(posedge clk);
    $display("simulation ran past its cycle limit");
    $display("Test failed");
    $finish;
  end

endmodule

//--- verilog.f
design/fetch_pkg.sv
design/cfg_pkg.sv
design/fetch_cfg_regs.sv
design/fetch_unit.sv
design/fetch_queue.sv
design/compressed_expander.sv
design/if_stage.sv
design/fetch_top.sv
sim/fetch_asserts.sv
sim/tb_fetch_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_fetch_top -o sim_fetch
./obj_dir/sim_fetch 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
